//--- rtl/zports_pkg.sv
// z80 i/o port block shared definitions
// port addresses, #BE readback selectors, reset values, ULAplus data byte

package zports_pkg;

	//////////////////////////////////////////////////
	// low address byte of each port
	//////////////////////////////////////////////////

	localparam logic [7:0] port_fe = 8'hFE; // border, beeper, keyboard
	localparam logic [7:0] port_f6 = 8'hF6; // border alias
	localparam logic [7:0] port_fc = 8'hFC; // border alias, also #7FFD alias
	localparam logic [7:0] port_fd = 8'hFD; // pentagon #7FFD
	localparam logic [7:0] port_f7 = 8'hF7; // #EFF7
	localparam logic [7:0] port_bf = 8'hBF; // evo config
	localparam logic [7:0] port_be = 8'hBE; // config readback, nmi clear
	localparam logic [7:0] port_3b = 8'h3B; // ulaplus reg/data

	//////////////////////////////////////////////////
	// #BE readback selectors, matched on a[12:8]
	//////////////////////////////////////////////////

	localparam logic [4:0] be_idx_7ffd   = 5'h0A;
	localparam logic [4:0] be_idx_eff7   = 5'h0B;
	localparam logic [4:0] be_idx_border = 5'h0F;

	// unmapped port or selector
	localparam logic [7:0] idle_byte = 8'hFF;

	// #BF bits {set_nmi, fntw_en, romrw_en, shadow_en} out of reset
	localparam logic [3:0] cfg_reset = 4'b0000;

	typedef logic [7:0] port_addr_t; // a[7:0]

	//////////////////////////////////////////////////
	// ulaplus data byte
	//////////////////////////////////////////////////

	// palette colour arrives as G3R3B2
	typedef struct packed {
		logic [2:0] green;
		logic [2:0] red;
		logic [1:0] blue;
	} up_pal_t;

	// mode group: only bit 0 is defined
	typedef struct packed {
		logic [6:0] rsvd;
		logic       ena;
	} up_mode_t;

	// same byte, meaning set by the selected group
	typedef union packed {
		up_pal_t  pal;
		up_mode_t mode;
	} up_data_u;

endpackage

//--- rtl/zbus_strobes.sv
// z80 bus strobe detection
// turns held iorq/mreq accesses into single fclk-wide strobes
`timescale 1ns/1ps

module zbus_strobes (
	input  logic fclk,
	input  logic rst_n,
	input  logic zpos,   // z80 clock rising edge, fclk wide
	input  logic iorq_n,
	input  logic mreq_n,
	input  logic rd_n,
	input  logic wr_n,
	output logic port_wr_fclk,
	output logic port_rd_fclk,
	output logic mem_wr_fclk
);

	logic [1:0] iowr_hist;  // [0] sampled on zpos, [1] one fclk later
	logic [1:0] iord_hist;
	logic [1:0] memwr_hist; // no zpos qualification here

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowr_hist    <= 2'b00;
			iord_hist    <= 2'b00;
			memwr_hist   <= 2'b00;
			port_wr_fclk <= 1'b0;
			port_rd_fclk <= 1'b0;
			mem_wr_fclk  <= 1'b0;
		end
		else
		begin
			if (zpos)
			begin
				iowr_hist[0] <= ~(iorq_n | wr_n);
				iord_hist[0] <= ~(iorq_n | rd_n);
			end
			iowr_hist[1]  <= iowr_hist[0];
			iord_hist[1]  <= iord_hist[0];
			memwr_hist    <= {memwr_hist[0], ~(mreq_n | wr_n)};
			port_wr_fclk  <= iowr_hist[0] & ~iowr_hist[1];   // rising edge only
			port_rd_fclk  <= iord_hist[0] & ~iord_hist[1];
			mem_wr_fclk   <= memwr_hist[0] & ~memwr_hist[1];
		end
	end

	// one io direction per access
	a_port_rw_excl: assert property (@(posedge fclk) disable iff (!rst_n)
		!(port_wr_fclk && port_rd_fclk));

	a_port_wr_single: assert property (@(posedge fclk) disable iff (!rst_n)
		port_wr_fclk |=> !port_wr_fclk);

	a_port_rd_single: assert property (@(posedge fclk) disable iff (!rst_n)
		port_rd_fclk |=> !port_rd_fclk);

endmodule

//--- rtl/port_decode.sv
// i/o port decoder
// low address byte to port hit, data-out enable and per-register write strobes
`timescale 1ns/1ps

module port_decode (
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        port_wr_fclk, // one-cycle io write strobe
	input  logic        shadow,       // dos or shadow_en
	output logic        porthit,
	output logic        dataout,
	output logic        wr_border,
	output logic        wr_7ffd,
	output logic        wr_eff7,
	output logic        wr_bf,
	output logic        wr_be,
	output logic        wr_up_reg,
	output logic        wr_up_data
);

	import zports_pkg::*;

	port_addr_t loa;

	logic hit_border; // FE, F6, FC
	logic hit_7ffd;   // FD, FC
	logic hit_f7;     // only outside shadow mode
	logic hit_up;

	assign loa = a[7:0];

	//////////////////////////////////////////////////
	// address match
	//////////////////////////////////////////////////

	assign hit_border = (loa == port_fe) || (loa == port_f6) || (loa == port_fc);
	assign hit_7ffd   = (loa == port_fd) || (loa == port_fc);
	assign hit_f7     = (loa == port_f7) && !shadow;
	assign hit_up     = (loa == port_3b);

	always_comb
	begin
		porthit = hit_border || hit_7ffd || hit_f7 || hit_up ||
		          (loa == port_bf) || (loa == port_be);
	end

	// z80 reads from us only while the bus says so
	assign dataout = porthit & ~iorq_n & ~rd_n;

	//////////////////////////////////////////////////
	// write strobes
	//////////////////////////////////////////////////

	assign wr_border = port_wr_fclk && hit_border;

	// a[15]=1 is the AY range, not ours
	assign wr_7ffd = port_wr_fclk && hit_7ffd && !a[15];

	// EFF7 style: a8 set, a12 clear
	assign wr_eff7 = port_wr_fclk && hit_f7 && a[8] && !a[12];

	assign wr_bf = port_wr_fclk && (loa == port_bf);
	assign wr_be = port_wr_fclk && (loa == port_be);

	// #BF3B register, #FF3B data
	assign wr_up_reg  = port_wr_fclk && hit_up && !a[14];
	assign wr_up_data = port_wr_fclk && hit_up &&  a[14];

endmodule

//--- rtl/pent_paging.sv
// pentagon paging registers #7FFD and #EFF7
// 1M block rules, masked views and the flat 1M page number
`timescale 1ns/1ps

module pent_paging (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       wr_7ffd,
	input  logic       wr_eff7,
	input  logic [7:0] din,
	output logic [7:0] p7ffd,       // masked view for the pager
	output logic [7:0] peff7,
	output logic [7:0] p7ffd_raw,   // as written, for #BE readback
	output logic [7:0] peff7_raw,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	logic block1m;   // eff7 bit 2, 128k-only mode
	logic block7ffd; // 48k lock plus block1m

	assign block1m   = peff7_raw[2];
	assign block7ffd = p7ffd_raw[5] & block1m;

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_raw <= 8'h00;
		else if (wr_7ffd && !block7ffd) // locked writes just drop
			p7ffd_raw <= din;           // 2:0 page, 3 scr, 4 rom, 5 lock, 7:6 hi page
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_raw <= 8'h00;
		else if (wr_eff7)
			peff7_raw <= din; // 0 p16c, 2 block1m, 3 ram0, 4 turbo off
	end

	//////////////////////////////////////////////////
	// masked views
	//////////////////////////////////////////////////

	// hi page bits vanish in 128k mode
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_raw[7:5]), p7ffd_raw[4:0]};

	assign peff7 = block1m ?
		{peff7_raw[7], 1'b0, peff7_raw[5:4], 3'b000, peff7_raw[0]} :
		peff7_raw;

	// 1M pager controls, taken from the raw values
	assign pent1m_page   = {p7ffd_raw[7:5], p7ffd_raw[2:0]};
	assign pent1m_rom    = p7ffd_raw[4];
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];

endmodule

//--- rtl/evo_config.sv
// evo config port #BF, border register and #BE readback
// also beeper, nmi clear and font write strobes
`timescale 1ns/1ps

module evo_config (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        dos,
	input  logic        mem_wr_fclk,
	input  logic        wr_bf,
	input  logic        wr_be,
	input  logic        wr_border,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic [7:0]  p7ffd_raw,
	input  logic [7:0]  peff7_raw,
	output logic        shadow,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic        beeper_wr,
	output logic        fnt_wr,
	output logic [3:0]  border,
	output logic [7:0]  cfg_read,
	output logic [7:0]  be_read
);

	import zports_pkg::*;

	logic shadow_en; // bf bit 0
	logic fntw_en;   // bf bit 2

	//////////////////////////////////////////////////
	// #BF config
	//////////////////////////////////////////////////

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			{set_nmi, fntw_en, romrw_en, shadow_en} <= cfg_reset;
		else if (wr_bf)
			{set_nmi, fntw_en, romrw_en, shadow_en} <= din[3:0];
	end

	assign shadow   = dos | shadow_en;
	assign cfg_read = {4'b0000, set_nmi, fntw_en, romrw_en, shadow_en};

	// border, bit 3 from inverted a3
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			border <= 4'h0;
		else if (wr_border)
			border <= {~a[3], din[2:0]};
	end

	// strobes, same cycle as the decode strobe
	assign beeper_wr = wr_border && (a[7:0] == port_fe); // aliases do not click
	assign clr_nmi   = wr_be;
	assign fnt_wr    = mem_wr_fclk && fntw_en;

	// #BE readback by high address
	always_comb
	begin
		case (a[12:8])
			be_idx_7ffd:   be_read = p7ffd_raw;
			be_idx_eff7:   be_read = peff7_raw;
			be_idx_border: be_read = {4'b0000, border};
			default:       be_read = idle_byte;
		endcase
	end

	// nmi end and a new config never come from one access
	a_nmi_clr_vs_cfg: assert property (@(posedge fclk) disable iff (!rst_n)
		!(clr_nmi && wr_bf));

endmodule

//--- rtl/ulaplus_regs.sv
// ulaplus #3B registers
// group select, palette address, mode enable and last written data byte
`timescale 1ns/1ps

module ulaplus_regs (
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       wr_up_reg,
	input  logic       wr_up_data,
	input  logic [7:0] din,
	output logic       up_ena,
	output logic       up_palwr,
	output logic [5:0] up_paladdr,
	output logic [7:0] up_paldata,   // R3G3B2
	output logic [7:0] up_lastwritten
);

	import zports_pkg::*;

	up_data_u din_u;
	logic     mode_grp; // 0 palette, 1 mode

	assign din_u = din;

	// register port, group in din[7:6]
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode_grp   <= 1'b0;
			up_paladdr <= 6'd0;
		end
		else if (wr_up_reg)
		begin
			if (din[7:6] == 2'b01)
				mode_grp <= 1'b1;
			else if (din[7:6] == 2'b00)
			begin
				mode_grp   <= 1'b0;
				up_paladdr <= din[5:0];
			end
		end
	end

	always_ff @(posedge fclk)
	begin
		if (wr_up_data)
			up_lastwritten <= din; // read back on #3B
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			up_ena <= 1'b0;
		else if (wr_up_data && mode_grp)
			up_ena <= din_u.mode.ena;
	end

	assign up_palwr   = wr_up_data && !mode_grp;
	assign up_paldata = {din_u.pal.red, din_u.pal.green, din_u.pal.blue}; // G3R3B2 in

endmodule

//--- rtl/zports_top.sv
// z80 i/o port block top
// bus strobes, decode, paging, config, ulaplus and the z80 read mux
`timescale 1ns/1ps

module zports_top (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        zpos,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        dos,
	input  logic        tape_read,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic [4:0]  keys_in,
	output logic [7:0]  dout,
	output logic        porthit,
	output logic        dataout,
	output logic [3:0]  border,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	output logic        romrw_en,
	output logic        set_nmi,
	output logic        clr_nmi,
	output logic        beeper_wr,
	output logic        fnt_wr,
	output logic        up_ena,
	output logic        up_palwr,
	output logic [5:0]  up_paladdr,
	output logic [7:0]  up_paldata
);

	import zports_pkg::*;

	logic port_wr_fclk, port_rd_fclk, mem_wr_fclk;
	logic wr_border, wr_7ffd, wr_eff7, wr_bf, wr_be, wr_up_reg, wr_up_data;
	logic shadow;
	logic [7:0] p7ffd_raw, peff7_raw;
	logic [7:0] cfg_read, be_read, up_lastwritten;
	port_addr_t loa;

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	zbus_strobes u_strobes (.fclk, .rst_n, .zpos, .iorq_n, .mreq_n, .rd_n, .wr_n,
		.port_wr_fclk, .port_rd_fclk, .mem_wr_fclk);

	port_decode u_decode (.a, .iorq_n, .rd_n, .port_wr_fclk, .shadow, .porthit,
		.dataout, .wr_border, .wr_7ffd, .wr_eff7, .wr_bf, .wr_be, .wr_up_reg, .wr_up_data);

	pent_paging u_paging (.fclk, .rst_n, .wr_7ffd, .wr_eff7, .din, .p7ffd, .peff7,
		.p7ffd_raw, .peff7_raw, .pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0);

	evo_config u_config (.fclk, .rst_n, .dos, .mem_wr_fclk, .wr_bf, .wr_be, .wr_border,
		.a, .din, .p7ffd_raw, .peff7_raw, .shadow, .romrw_en, .set_nmi, .clr_nmi,
		.beeper_wr, .fnt_wr, .border, .cfg_read, .be_read);

	ulaplus_regs u_ulaplus (.fclk, .rst_n, .wr_up_reg, .wr_up_data, .din, .up_ena,
		.up_palwr, .up_paladdr, .up_paldata, .up_lastwritten);

	// z80 read data, valid only with dataout
	assign loa = a[7:0];

	always_comb
	begin
		case (loa)
			port_fe, port_f6: dout = {1'b1, tape_read, 1'b0, keys_in};
			port_bf:          dout = cfg_read;
			port_be:          dout = be_read;
			port_3b:          dout = up_lastwritten;
			default:          dout = idle_byte;
		endcase
	end

	// read strobe lands while the z80 still holds its read cycle
	a_rd_in_cycle: assert property (@(posedge fclk) disable iff (!rst_n)
		port_rd_fclk |-> (!iorq_n && !rd_n));

endmodule

//--- testbench/tb_clock.sv
// testbench clock and reset source
// fclk at 4 ns, zpos every second fclk, rst_n low for 3 cycles
`timescale 1ns/1ps

module tb_clock (
	output logic fclk,
	output logic zpos,
	output logic rst_n
);

	initial
	begin
		fclk  = 1'b0;
		zpos  = 1'b0;
		rst_n = 1'b0;
		fork
			forever #2 fclk = ~fclk; // 4 ns period
		join_none
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		rst_n = 1'b1; // release away from the active edge
	end

	always @(negedge fclk)
		zpos <= ~zpos; // z80 clock at half fclk

endmodule

//--- testbench/zports_tb.sv
// z80 i/o port block testbench
// directed bus accesses, checked against the port rules
`timescale 1ns/1ps

module zports_tb;

	// about 30 accesses of 13 cycles each plus a wide margin
	localparam int max_cycles = 2000;

	logic fclk, zpos, rst_n;
	logic iorq_n, mreq_n, rd_n, wr_n, dos, tape_read;
	logic [15:0] a;
	logic [7:0]  din;
	logic [4:0]  keys_in;
	logic [7:0]  dout, p7ffd, peff7, up_paldata;
	logic [3:0]  border;
	logic [5:0]  pent1m_page, up_paladdr;
	logic porthit, dataout, pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic romrw_en, set_nmi, clr_nmi, beeper_wr, fnt_wr, up_ena, up_palwr;

	int cycle_cnt = 0;
	int beep_cnt = 0;
	int nmi_cnt = 0;
	int fnt_cnt = 0;
	int palwr_cnt = 0;
	logic [7:0] pal_seen;    // up_paldata at the last palette strobe
	logic [3:0] exp_border;  // border as the tests last wrote it

	tb_clock clk_gen (.fclk, .zpos, .rst_n);

	zports_top uut (.fclk, .rst_n, .zpos, .iorq_n, .mreq_n, .rd_n, .wr_n, .dos,
		.tape_read, .a, .din, .keys_in, .dout, .porthit, .dataout, .border, .p7ffd,
		.peff7, .pent1m_page, .pent1m_rom, .pent1m_1m_on, .pent1m_ram0_0, .romrw_en,
		.set_nmi, .clr_nmi, .beeper_wr, .fnt_wr, .up_ena, .up_palwr, .up_paladdr,
		.up_paldata);

	//////////////////////////////////////////////////
	// pulse counters and timeout
	//////////////////////////////////////////////////

	always @(posedge fclk)
	begin
		if (beeper_wr) beep_cnt <= beep_cnt + 1;
		if (clr_nmi)   nmi_cnt <= nmi_cnt + 1;
		if (fnt_wr)    fnt_cnt <= fnt_cnt + 1;
		if (up_palwr)
		begin
			palwr_cnt <= palwr_cnt + 1;
			pal_seen  <= up_paldata; // data valid with the strobe
		end
	end

	always @(posedge fclk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == max_cycles)
		begin
			$display("timeout: tests did not finish within %0d cycles", max_cycles);
			$display("TB FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	//////////////////////////////////////////////////
	// bus tasks
	//////////////////////////////////////////////////

	task automatic expect_equal(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// io write held 8 cycles then 4 idle
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge fclk);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (8) @(negedge fclk);
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (4) @(negedge fclk);
	endtask

	// io read with data and dataout sampled late in the access
	task automatic io_read(input logic [15:0] addr, output logic [7:0] data,
		output logic de);
		@(negedge fclk);
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		repeat (6) @(negedge fclk);
		data = dout;
		de   = dataout;
		repeat (2) @(negedge fclk);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (4) @(negedge fclk);
	endtask

	task automatic mem_write(input logic [15:0] addr);
		@(negedge fclk);
		a      = addr;
		mreq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (8) @(negedge fclk);
		mreq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (4) @(negedge fclk);
	endtask

	// address only with no strobe
	task automatic probe_porthit(input logic [15:0] addr, input logic exp);
		@(negedge fclk);
		a = addr;
		@(negedge fclk);
		expect_equal("porthit", 16'(porthit), 16'(exp));
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic reset_defaults();
		logic [7:0] rd;
		logic de;
		expect_equal("p7ffd", 16'(p7ffd), 16'h0);
		expect_equal("peff7", 16'(peff7), 16'h0);
		expect_equal("up_ena", 16'(up_ena), 16'h0);
		expect_equal("up_paladdr", 16'(up_paladdr), 16'h0);
		expect_equal("romrw_en", 16'(romrw_en), 16'h0);
		expect_equal("set_nmi", 16'(set_nmi), 16'h0);
		expect_equal("pent1m_1m_on", 16'(pent1m_1m_on), 16'h1);
		io_read(16'h00BF, rd, de);
		expect_equal("dout bf", 16'(rd), 16'h0);
		io_read(16'h0ABE, rd, de);  // selector A is 7ffd
		expect_equal("dout be A", 16'(rd), 16'h0);
		io_read(16'h0BBE, rd, de);
		expect_equal("dout be B", 16'(rd), 16'h0);
		io_read(16'h0011, rd, de);  // nothing mapped here
		expect_equal("dout idle", 16'(rd), 16'h00FF);
		expect_equal("dataout idle", 16'(de), 16'h0);
	endtask

	task automatic border_keyboard();
		logic [7:0] d, rd;
		logic de;
		int b0;
		d  = 8'($urandom);
		b0 = beep_cnt;
		io_write(16'h00FE, d);      // a3 is set in FE
		expect_equal("border", 16'(border), 16'({1'b0, d[2:0]}));
		expect_equal("beeper_wr pulses", 16'(beep_cnt - b0), 16'd1);
		d  = 8'($urandom);
		b0 = beep_cnt;
		io_write(16'h00F6, d);      // alias with a3 clear
		exp_border = {1'b1, d[2:0]};
		expect_equal("border", 16'(border), 16'(exp_border));
		expect_equal("beeper_wr pulses", 16'(beep_cnt - b0), 16'd0);
		tape_read = 1'b1;
		keys_in   = 5'($urandom);
		io_read(16'h7FFE, rd, de);
		expect_equal("dout fe", 16'(rd), 16'({1'b1, tape_read, 1'b0, keys_in}));
		expect_equal("dataout fe", 16'(de), 16'h1);
	endtask

	task automatic paging_blocks();
		logic [7:0] d, d2, e, rd;
		logic de;
		d = 8'($urandom) & 8'hDF;   // lock bit clear for now
		io_write(16'h7FFD, d);
		expect_equal("p7ffd", 16'(p7ffd), 16'(d));
		expect_equal("pent1m_page", 16'(pent1m_page), 16'({d[7:5], d[2:0]}));
		expect_equal("pent1m_rom", 16'(pent1m_rom), 16'(d[4]));
		e = 8'($urandom) | 8'h04;   // block1m on
		io_write(16'hEFF7, e);
		expect_equal("peff7", 16'(peff7), 16'(e & 8'hB1));  // 6,3,2,1 cleared
		expect_equal("p7ffd masked", 16'(p7ffd), 16'({3'b000, d[4:0]}));
		expect_equal("pent1m_1m_on", 16'(pent1m_1m_on), 16'h0);
		expect_equal("pent1m_ram0_0", 16'(pent1m_ram0_0), 16'(e[3]));
		d2 = 8'($urandom) | 8'h20;  // sets the lock
		io_write(16'h7FFD, d2);
		io_write(16'h7FFD, ~d2);    // must be dropped
		expect_equal("p7ffd locked", 16'(p7ffd), 16'({3'b000, d2[4:0]}));
		io_read(16'h0ABE, rd, de);
		expect_equal("dout be A", 16'(rd), 16'(d2));
	endtask

	task automatic config_readback();
		logic [7:0] c, rd;
		logic de;
		int n0, f0;
		c = 8'($urandom);
		io_write(16'h00BF, c);
		expect_equal("romrw_en", 16'(romrw_en), 16'(c[1]));
		expect_equal("set_nmi", 16'(set_nmi), 16'(c[3]));
		io_read(16'h00BF, rd, de);
		expect_equal("dout bf", 16'(rd), 16'({4'h0, c[3:0]}));
		io_write(16'h00BF, 8'h00);
		probe_porthit(16'hEFF7, 1'b1);
		dos = 1'b1;                 // dos alone also hides F7
		probe_porthit(16'hEFF7, 1'b0);
		dos = 1'b0;
		io_write(16'h00BF, 8'h01);  // shadow_en
		probe_porthit(16'hEFF7, 1'b0);
		io_write(16'h00BF, 8'h00);
		io_read(16'h0FBE, rd, de);
		expect_equal("dout be F", 16'(rd), 16'({4'h0, exp_border}));
		n0 = nmi_cnt;
		io_write(16'h00BE, 8'($urandom));
		expect_equal("clr_nmi pulses", 16'(nmi_cnt - n0), 16'd1);
		f0 = fnt_cnt;
		mem_write(16'h4000);        // font writes off
		expect_equal("fnt_wr pulses", 16'(fnt_cnt - f0), 16'd0);
		io_write(16'h00BF, 8'h04);
		f0 = fnt_cnt;
		mem_write(16'h4001);
		expect_equal("fnt_wr pulses", 16'(fnt_cnt - f0), 16'd1);
		io_write(16'h00BF, 8'h00);
	endtask

	task automatic ulaplus_palette_mode();
		logic [7:0] p, v, rd;
		logic de;
		int w0;
		p = 8'($urandom) & 8'h3F;   // palette group
		io_write(16'hBF3B, p);
		expect_equal("up_paladdr", 16'(up_paladdr), 16'(p[5:0]));
		v  = 8'($urandom);
		w0 = palwr_cnt;
		io_write(16'hFF3B, v);
		expect_equal("up_palwr pulses", 16'(palwr_cnt - w0), 16'd1);
		expect_equal("up_paldata", 16'(pal_seen), 16'({v[4:2], v[7:5], v[1:0]}));
		io_read(16'hFF3B, rd, de);
		expect_equal("dout 3b", 16'(rd), 16'(v));
		io_write(16'hBF3B, 8'h40);  // mode group
		w0 = palwr_cnt;
		io_write(16'hFF3B, 8'h01);
		expect_equal("up_ena", 16'(up_ena), 16'h1);
		io_write(16'hFF3B, 8'h00);
		expect_equal("up_ena", 16'(up_ena), 16'h0);
		expect_equal("up_palwr pulses", 16'(palwr_cnt - w0), 16'd0);
	endtask

	initial
	begin
		void'($urandom(32'h3a1a_77dc));
		iorq_n    = 1'b1;
		mreq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		tape_read = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		keys_in   = 5'h1F;
		exp_border = 4'h0;
		@(posedge rst_n);
		@(negedge fclk);
		reset_defaults();
		border_keyboard();
		paging_blocks();
		config_readback();
		ulaplus_palette_mode();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- verilog.f
rtl/zports_pkg.sv
rtl/zbus_strobes.sv
rtl/port_decode.sv
rtl/pent_paging.sv
rtl/evo_config.sv
rtl/ulaplus_regs.sv
rtl/zports_top.sv
testbench/tb_clock.sv
testbench/zports_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = zports_tb
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

# pass only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
